// ==== filelist.f ====
+incdir+logic
logic/calc_pkg.sv
logic/ps2_receiver.sv
logic/scan_decoder.sv
logic/calc_control.sv
logic/calc_alu.sv
logic/bin_to_bcd.sv
logic/seg_mux.sv
logic/keypad_calculator.sv
test/display_checker.sv
test/tb_keypad_calculator.sv

// ==== logic/bin_to_bcd.sv ====
`timescale 1ns/1ps
`include "calc_settings.svh"

module bin_to_bcd (
  input  logic           clk,
  input  logic           rst,
  input  logic           conv_start,
  input  calc_pkg::mag_t conv_value,
  output logic           conv_busy,
  output calc_pkg::bcd_t bcd
);

  localparam int cnt_w = $clog2(`CALC_MAG_W);

  calc_pkg::mag_t   bin;                  // bits still to shift in, msb first
  calc_pkg::bcd_t   work;
  calc_pkg::bcd_t   adj;
  calc_pkg::bcd_t   work_next;
  logic [cnt_w-1:0] cnt;

  // add 3 to every nibble of 5 or more, then shift one bit in
  always_comb begin
    for (int i = 0; i < `CALC_DIGITS; i++) begin
      adj[4*i +: 4] = (work[4*i +: 4] >= 4'd5) ? work[4*i +: 4] + 4'd3 : work[4*i +: 4];
    end
    work_next = {adj[4*`CALC_DIGITS-2:0], bin[`CALC_MAG_W-1]};
  end

  always_ff @(posedge clk) begin
    if (conv_start) begin
      bin  <= conv_value;
      work <= '0;
    end else if (conv_busy) begin
      bin  <= bin << 1;
      work <= work_next;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      conv_busy <= 1'b0;
      cnt       <= '0;
      bcd       <= '0;
    end else if (conv_start) begin
      conv_busy <= 1'b1;
      cnt       <= '0;
    end else if (conv_busy) begin
      if (cnt == cnt_w'(`CALC_MAG_W - 1)) begin
        conv_busy <= 1'b0;
        bcd       <= work_next;           // last shift lands on the output
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

// ==== logic/calc_alu.sv ====
`timescale 1ns/1ps
`include "calc_settings.svh"

module calc_alu (
  input  calc_pkg::mag_t     acc,
  input  logic               acc_neg,
  input  calc_pkg::mag_t     operand,
  input  calc_pkg::calc_op_t op,
  output calc_pkg::mag_t     res_mag,
  output logic               res_neg
);

  localparam int ww = 2 * `CALC_MAG_W;    // wide enough for 999*999

  logic [ww-1:0] a_w;
  logic [ww-1:0] b_w;
  logic [ww-1:0] raw_mag;
  logic          b_neg;                   // operand sign after the operator
  logic          raw_neg;

  always_comb begin
    a_w     = ww'(acc);
    b_w     = ww'(operand);
    b_neg   = (op == calc_pkg::op_sub);
    raw_mag = a_w;
    raw_neg = acc_neg;
    case (op)
      calc_pkg::op_add, calc_pkg::op_sub: begin
        if (acc_neg == b_neg) begin
          raw_mag = a_w + b_w;            // same signs, magnitudes add
        end else if (a_w >= b_w) begin
          raw_mag = a_w - b_w;
        end else begin
          raw_mag = b_w - a_w;
          raw_neg = b_neg;
        end
      end
      calc_pkg::op_mul: raw_mag = a_w * b_w;
      default: ;
    endcase
  end

  assign res_mag = (raw_mag > ww'(`CALC_MAX_MAG)) ? calc_pkg::mag_t'(`CALC_MAX_MAG)
                                                  : calc_pkg::mag_t'(raw_mag);
  assign res_neg = raw_neg & (raw_mag != '0);   // zero is always positive

endmodule

// ==== logic/calc_control.sv ====
`timescale 1ns/1ps
`include "calc_settings.svh"

module calc_control (
  input  logic                clk,
  input  logic                rst,
  input  logic                key_valid,
  input  calc_pkg::key_kind_t key_kind,
  input  logic [3:0]          key_digit,
  input  calc_pkg::mag_t      res_mag,
  input  logic                res_neg,
  input  logic                conv_busy,
  output calc_pkg::mag_t      acc,
  output logic                acc_neg,
  output calc_pkg::mag_t      operand,
  output calc_pkg::calc_op_t  op,
  output logic                conv_start,
  output calc_pkg::mag_t      conv_value,
  output logic                show_minus
);

  logic [13:0]        entry_ext;          // operand*10 + digit, no overflow
  logic               entry_ok;
  logic               fresh;              // result on display, no digit since Enter
  calc_pkg::calc_op_t op_key;

  assign entry_ext = 14'(operand) * 14'd10 + 14'(key_digit);
  assign entry_ok  = entry_ext <= 14'(`CALC_MAX_MAG);

  always_comb begin
    case (key_kind)
      calc_pkg::key_add: op_key = calc_pkg::op_add;
      calc_pkg::key_sub: op_key = calc_pkg::op_sub;
      calc_pkg::key_mul: op_key = calc_pkg::op_mul;
      default:           op_key = calc_pkg::op_none;
    endcase
  end

  ////////////////////
  // key handling
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      acc        <= '0;
      acc_neg    <= 1'b0;
      operand    <= '0;
      op         <= calc_pkg::op_none;
      fresh      <= 1'b0;
      conv_start <= 1'b0;
      conv_value <= '0;
      show_minus <= 1'b0;
    end else begin
      conv_start <= 1'b0;
      if (key_valid && !conv_busy) begin
        case (key_kind)
          calc_pkg::key_digit: begin
            if (entry_ok) begin           // a fourth digit is dropped
              operand    <= calc_pkg::mag_t'(entry_ext);
              fresh      <= 1'b0;
              conv_start <= 1'b1;
              conv_value <= calc_pkg::mag_t'(entry_ext);
              show_minus <= 1'b0;
            end
          end
          calc_pkg::key_add, calc_pkg::key_sub, calc_pkg::key_mul: begin
            if (!fresh) begin             // otherwise chain on the last result
              acc     <= operand;
              acc_neg <= 1'b0;
            end
            op      <= op_key;
            operand <= '0;
          end
          calc_pkg::key_clear: begin
            acc        <= '0;
            acc_neg    <= 1'b0;
            operand    <= '0;
            op         <= calc_pkg::op_none;
            fresh      <= 1'b0;
            conv_start <= 1'b1;
            conv_value <= '0;
            show_minus <= 1'b0;
          end
          calc_pkg::key_enter: begin
            if (op != calc_pkg::op_none) begin
              acc        <= res_mag;
              acc_neg    <= res_neg;
              operand    <= '0;           // next digit starts a new operand
              op         <= calc_pkg::op_none;
              fresh      <= 1'b1;
              conv_start <= 1'b1;
              conv_value <= res_mag;
              show_minus <= res_neg;
            end
          end
          default: ;
        endcase
      end
    end
  end

endmodule

// ==== logic/calc_pkg.sv ====
`include "calc_settings.svh"

package calc_pkg;

  // key classes delivered by the scan decoder
  typedef enum logic [2:0] {
    key_digit,
    key_add,
    key_sub,
    key_mul,
    key_clear,
    key_enter
  } key_kind_t;

  typedef enum logic [1:0] {
    op_none,
    op_add,
    op_sub,
    op_mul
  } calc_op_t;

  typedef logic [`CALC_MAG_W-1:0] mag_t;          // unsigned magnitude
  typedef logic [4*`CALC_DIGITS-1:0] bcd_t;       // hundreds, tens, ones

endpackage

// ==== logic/calc_settings.svh ====
`ifndef CALC_SETTINGS_SVH
`define CALC_SETTINGS_SVH

`define CALC_MAG_W            10      // magnitude width, holds up to 1023
`define CALC_MAX_MAG          999     // saturation limit
`define CALC_DIGITS           3       // decimal digits shown
`define CALC_DEBOUNCE_CYCLES  15      // stable cycles before a line change counts
`define CALC_PS2_BITS         11      // start, 8 data, parity, stop

`define CALC_CODE_BREAK   8'hF0
`define CALC_CODE_EXTEND  8'hE0
`define CALC_CODE_ADD     8'h1C       // A
`define CALC_CODE_SUB     8'h1B       // S
`define CALC_CODE_MUL     8'h22       // X
`define CALC_CODE_CLEAR   8'h21       // C
`define CALC_CODE_ENTER   8'h5A

// digit codes 0 to 9, leftmost byte is digit 0
`define CALC_ROW_CODES    80'h45_16_1E_26_25_2E_36_3D_3E_46
`define CALC_PAD_CODES    80'h70_69_72_7A_6B_73_74_6C_75_7D
`define CALC_ROW_CODE(i)  8'(`CALC_ROW_CODES >> (8 * (9 - (i))))
`define CALC_PAD_CODE(i)  8'(`CALC_PAD_CODES >> (8 * (9 - (i))))

`endif

// ==== logic/keypad_calculator.sv ====
`timescale 1ns/1ps

module keypad_calculator #(
  parameter int scan_bits = 16
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output logic [3:0] digit,
  output logic [6:0] segments
);

  logic [7:0]          rx_byte;
  logic                rx_valid;
  logic                key_valid;
  calc_pkg::key_kind_t key_kind;
  logic [3:0]          key_digit;
  calc_pkg::mag_t      acc;
  logic                acc_neg;
  calc_pkg::mag_t      operand;
  calc_pkg::calc_op_t  op;
  calc_pkg::mag_t      res_mag;
  logic                res_neg;
  logic                conv_start;
  calc_pkg::mag_t      conv_value;
  logic                conv_busy;
  calc_pkg::bcd_t      bcd;
  logic                show_minus;

  ////////////////////
  // keyboard front end
  ps2_receiver u_rx (
    .clk(clk), .rst(rst), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
    .rx_byte(rx_byte), .rx_valid(rx_valid)
  );

  scan_decoder u_dec (
    .clk(clk), .rst(rst), .rx_byte(rx_byte), .rx_valid(rx_valid),
    .key_valid(key_valid), .key_kind(key_kind), .key_digit(key_digit)
  );

  ////////////////////
  // calculator core
  calc_control u_ctrl (
    .clk(clk), .rst(rst), .key_valid(key_valid), .key_kind(key_kind),
    .key_digit(key_digit), .res_mag(res_mag), .res_neg(res_neg),
    .conv_busy(conv_busy), .acc(acc), .acc_neg(acc_neg), .operand(operand),
    .op(op), .conv_start(conv_start), .conv_value(conv_value),
    .show_minus(show_minus)
  );

  calc_alu u_alu (
    .acc(acc), .acc_neg(acc_neg), .operand(operand), .op(op),
    .res_mag(res_mag), .res_neg(res_neg)
  );

  bin_to_bcd u_bcd (
    .clk(clk), .rst(rst), .conv_start(conv_start), .conv_value(conv_value),
    .conv_busy(conv_busy), .bcd(bcd)
  );

  seg_mux #(.scan_bits(scan_bits)) u_seg (
    .clk(clk), .rst(rst), .bcd(bcd), .show_minus(show_minus),
    .digit(digit), .segments(segments)
  );

endmodule

// ==== logic/ps2_receiver.sv ====
`timescale 1ns/1ps
`include "calc_settings.svh"

module ps2_receiver (
  input  logic       clk,
  input  logic       rst,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output logic [7:0] rx_byte,
  output logic       rx_valid
);

  localparam int cw = $clog2(`CALC_DEBOUNCE_CYCLES + 1);
  localparam logic [cw-1:0] db_max = cw'(`CALC_DEBOUNCE_CYCLES);

  logic [1:0]    line_in;                   // bit 0 clock, bit 1 data
  logic [1:0]    line_raw;                  // last raw sample
  logic [1:0]    line_s;                    // debounced level
  logic [cw-1:0] db_cnt [2];
  logic          clk_prev;
  logic          clk_fall;
  logic [3:0]    bit_cnt;
  logic [`CALC_PS2_BITS-1:0] frame;
  logic          frame_ok;

  assign line_in  = {ps2_data, ps2_clk};
  assign clk_fall = clk_prev & ~line_s[0];

  ////////////////////
  // line debouncing
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      line_raw <= 2'b11;                    // idle bus is high
      line_s   <= 2'b11;
      db_cnt   <= '{default: '0};
      clk_prev <= 1'b1;
    end else begin
      clk_prev <= line_s[0];
      for (int i = 0; i < 2; i++) begin
        if (line_in[i] != line_raw[i]) begin
          line_raw[i] <= line_in[i];
          db_cnt[i]   <= '0;                // restart on any change
        end else if (db_cnt[i] == db_max) begin
          line_s[i] <= line_raw[i];
        end else begin
          db_cnt[i] <= db_cnt[i] + 1'b1;
        end
      end
    end
  end

  ////////////////////
  // frame assembly, lsb first
  always_ff @(posedge clk) begin
    if (clk_fall) begin
      frame <= {line_s[1], frame[`CALC_PS2_BITS-1:1]};
    end
  end

  // start low, stop high, odd parity over data and parity bit
  assign frame_ok = ~frame[0] & frame[`CALC_PS2_BITS-1] & (^frame[9:1]);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (clk_fall) begin
        bit_cnt <= bit_cnt + 1'b1;
      end else if (bit_cnt == 4'(`CALC_PS2_BITS)) begin
        bit_cnt  <= '0;
        rx_valid <= frame_ok;               // bad frames vanish here
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bit_cnt == 4'(`CALC_PS2_BITS) && !clk_fall && frame_ok) begin
      rx_byte <= frame[8:1];
    end
  end

endmodule

// ==== logic/scan_decoder.sv ====
`timescale 1ns/1ps
`include "calc_settings.svh"

module scan_decoder (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [7:0]           rx_byte,
  input  logic                 rx_valid,
  output logic                 key_valid,
  output calc_pkg::key_kind_t  key_kind,
  output logic [3:0]           key_digit
);

  logic                brk;               // F0 seen
  logic                ext;               // E0 seen
  logic                known;
  logic                is_prefix;
  calc_pkg::key_kind_t kind_c;
  logic [3:0]          digit_c;

  assign is_prefix = (rx_byte == `CALC_CODE_BREAK) || (rx_byte == `CALC_CODE_EXTEND);

  always_comb begin
    known   = 1'b1;
    kind_c  = calc_pkg::key_digit;
    digit_c = 4'd0;
    case (rx_byte)
      `CALC_CODE_ADD:   kind_c = calc_pkg::key_add;
      `CALC_CODE_SUB:   kind_c = calc_pkg::key_sub;
      `CALC_CODE_MUL:   kind_c = calc_pkg::key_mul;
      `CALC_CODE_CLEAR: kind_c = calc_pkg::key_clear;
      `CALC_CODE_ENTER: kind_c = calc_pkg::key_enter;
      default: begin
        known = 1'b0;
        for (int i = 0; i < 10; i++) begin
          if (rx_byte == `CALC_ROW_CODE(i) || rx_byte == `CALC_PAD_CODE(i)) begin
            known   = 1'b1;             // main row or numpad
            digit_c = 4'(i);
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      brk       <= 1'b0;
      ext       <= 1'b0;
      key_valid <= 1'b0;
    end else begin
      key_valid <= 1'b0;
      if (rx_valid) begin
        if (rx_byte == `CALC_CODE_BREAK) begin
          brk <= 1'b1;
        end else if (rx_byte == `CALC_CODE_EXTEND) begin
          ext <= 1'b1;
        end else begin
          brk       <= 1'b0;            // prefixes last one byte
          ext       <= 1'b0;
          key_valid <= known & ~brk & ~ext;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid && !is_prefix) begin
      key_kind  <= kind_c;
      key_digit <= digit_c;
    end
  end

endmodule

// ==== logic/seg_mux.sv ====
`timescale 1ns/1ps

module seg_mux #(
  parameter int scan_bits = 16            // 2**scan_bits cycles per digit
) (
  input  logic           clk,
  input  logic           rst,
  input  calc_pkg::bcd_t bcd,
  input  logic           show_minus,
  output logic [3:0]     digit,
  output logic [6:0]     segments
);

  logic [scan_bits+1:0] scan_cnt;
  logic                 active;           // low until the first slot has passed
  logic [1:0]           sel;
  logic [3:0]           nib;
  logic                 blank;
  logic                 minus;

  assign sel = scan_cnt[scan_bits+1:scan_bits];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      scan_cnt <= '0;
      active   <= 1'b0;
    end else begin
      scan_cnt <= scan_cnt + 1'b1;
      if (&scan_cnt[scan_bits-1:0]) active <= 1'b1;
    end
  end

  ////////////////////
  // digit selection and blanking
  always_comb begin
    nib   = bcd[3:0];                     // ones, always shown
    blank = 1'b0;
    minus = 1'b0;
    case (sel)
      2'd1: begin
        nib   = bcd[7:4];
        blank = (bcd[11:4] == '0);
      end
      2'd2: begin
        nib   = bcd[11:8];
        blank = (bcd[11:8] == '0);
      end
      2'd3: begin
        minus = show_minus;
        blank = ~show_minus;
      end
      default: ;
    endcase
  end

  assign digit = active ? ~(4'b0001 << sel) : 4'b1111;

  always_comb begin
    if (!active || blank) begin
      segments = 7'b1111111;
    end else if (minus) begin
      segments = 7'b0111111;              // segment g only
    end else begin
      case (nib)
        4'd0:    segments = 7'b1000000;
        4'd1:    segments = 7'b1111001;
        4'd2:    segments = 7'b0100100;
        4'd3:    segments = 7'b0110000;
        4'd4:    segments = 7'b0011001;
        4'd5:    segments = 7'b0010010;
        4'd6:    segments = 7'b0000010;
        4'd7:    segments = 7'b1111000;
        4'd8:    segments = 7'b0000000;
        4'd9:    segments = 7'b0010000;
        default: segments = 7'b1111111;
      endcase
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the keypad calculator testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_keypad_calculator -f filelist.f &&
./obj_dir/Vtb_keypad_calculator | tee /dev/stderr | grep -q "Test completed successfully" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== test/display_checker.sv ====
`timescale 1ns/1ps

module display_checker (
  input  logic        clk,
  input  logic        rst,
  input  logic [3:0]  digit,
  input  logic [6:0]  segments,
  input  logic        check,
  input  logic [11:0] exp_value,
  input  logic        exp_minus,
  output int          checks,
  output int          errors
);

  logic [3:0] shown [4];                    // slot 0 is the ones digit
  int         slot_errors;
  int         value_errors;

  assign errors = slot_errors + value_errors;

  // active-low gfedcba, A for minus, F for blank
  function automatic logic [3:0] decode_segments(input logic [6:0] seg);
    case (seg)
      7'b1000000: return 4'h0;
      7'b1111001: return 4'h1;
      7'b0100100: return 4'h2;
      7'b0110000: return 4'h3;
      7'b0011001: return 4'h4;
      7'b0010010: return 4'h5;
      7'b0000010: return 4'h6;
      7'b1111000: return 4'h7;
      7'b0000000: return 4'h8;
      7'b0010000: return 4'h9;
      7'b0111111: return 4'hA;
      7'b1111111: return 4'hF;
      default:    return 4'hE;              // no legal pattern
    endcase
  endfunction

  function automatic logic [15:0] expected_display(input logic [11:0] value, input logic minus);
    logic [3:0] left;
    logic [3:0] hund;
    logic [3:0] tens;
    left = minus ? 4'hA : 4'hF;
    hund = (value[11:8] == 4'h0) ? 4'hF : value[11:8];
    tens = (value[11:4] == 8'h00) ? 4'hF : value[7:4];
    return {left, hund, tens, value[3:0]};
  endfunction

  ////////////////////
  // slot capture and compare
  always @(posedge clk or posedge rst) begin
    if (rst) begin
      shown        <= '{default: 4'hF};
      checks       <= 0;
      slot_errors  <= 0;
      value_errors <= 0;
    end else begin
      case (digit)
        4'b1110: shown[0] <= decode_segments(segments);
        4'b1101: shown[1] <= decode_segments(segments);
        4'b1011: shown[2] <= decode_segments(segments);
        4'b0111: shown[3] <= decode_segments(segments);
        4'b1111: ;                          // before the first slot
        default: begin
          $display("ERR digit: expected one active slot, actual %h", digit);
          slot_errors <= slot_errors + 1;
        end
      endcase
      if (check) begin
        checks <= checks + 1;
        if ({shown[3], shown[2], shown[1], shown[0]} !=
            expected_display(exp_value, exp_minus)) begin
          $display("ERR segments check %0d: expected %h, actual %h", checks,
                   expected_display(exp_value, exp_minus),
                   {shown[3], shown[2], shown[1], shown[0]});
          value_errors <= value_errors + 1;
        end
      end
    end
  end

endmodule

// ==== test/tb_keypad_calculator.sv ====
`timescale 1ns/1ps
`include "calc_settings.svh"

module tb_keypad_calculator;

  localparam int n_rows = 16;
  localparam int max_cycles = n_rows * 6 * 3 * `CALC_PS2_BITS * 80 * 2;

  localparam logic [7:0] k_nil = 8'hFF;              // empty key slot
  localparam logic [7:0] k_bad = 8'hFE;              // digit frame with wrong parity
  localparam logic [7:0] k_rel = `CALC_CODE_BREAK;   // lone release of a digit
  localparam logic [7:0] k_ext = `CALC_CODE_EXTEND;  // E0-prefixed press and release
  localparam logic [7:0] k_add = `CALC_CODE_ADD;
  localparam logic [7:0] k_sub = `CALC_CODE_SUB;
  localparam logic [7:0] k_mul = `CALC_CODE_MUL;
  localparam logic [7:0] k_clr = `CALC_CODE_CLEAR;
  localparam logic [7:0] k_ent = `CALC_CODE_ENTER;

  // six keys, expected value as three bcd digits, expected minus
  localparam logic [60:0] rows_tab [n_rows] = '{
    {k_nil, k_nil, k_nil, k_nil, k_nil, k_nil, 12'h000, 1'b0},  // after reset
    {8'd1,  8'd2,  8'd3,  8'd4,  k_nil, k_nil, 12'h123, 1'b0},  // fourth digit dropped
    {k_clr, 8'd7,  k_nil, k_nil, k_nil, k_nil, 12'h007, 1'b0},
    {k_clr, 8'd4,  8'd5,  k_add, 8'd5,  8'd5,  12'h055, 1'b0},
    {k_ent, k_nil, k_nil, k_nil, k_nil, k_nil, 12'h100, 1'b0},
    {k_clr, 8'd9,  8'd0,  8'd0,  k_add, 8'd2,  12'h002, 1'b0},
    {8'd0,  8'd0,  k_ent, k_nil, k_nil, k_nil, 12'h999, 1'b0},  // 900+200 saturates
    {k_clr, 8'd5,  k_sub, 8'd1,  8'd2,  k_ent, 12'h007, 1'b1},
    {8'd3,  k_nil, k_nil, k_nil, k_nil, k_nil, 12'h003, 1'b0},  // new operand
    {k_clr, 8'd5,  k_sub, 8'd1,  8'd2,  k_ent, 12'h007, 1'b1},
    {k_add, 8'd1,  8'd0,  k_ent, k_nil, k_nil, 12'h003, 1'b0},  // chains on -7
    {k_clr, 8'd2,  8'd5,  k_mul, 8'd4,  k_ent, 12'h100, 1'b0},
    {8'd5,  8'd0,  k_mul, 8'd3,  8'd0,  k_ent, 12'h999, 1'b0},
    {k_clr, k_nil, k_nil, k_nil, k_nil, k_nil, 12'h000, 1'b0},
    {k_clr, 8'd8,  k_rel, k_ext, k_bad, k_nil, 12'h008, 1'b0},  // ignored traffic
    {k_sub, 8'd9,  k_ent, k_rel, k_ext, k_bad, 12'h001, 1'b1}
  };

  logic        clk = 1'b0;
  logic        rst;
  logic        ps2_clk;
  logic        ps2_data;
  logic [3:0]  digit;
  logic [6:0]  segments;
  logic        check;
  logic [11:0] exp_value;
  logic        exp_minus;
  int          checks;
  int          errors;
  int          cycles = 0;

  always #20 clk = ~clk;

  keypad_calculator #(.scan_bits(3)) uut (
    .clk(clk), .rst(rst), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
    .digit(digit), .segments(segments)
  );

  display_checker u_checker (
    .clk(clk), .rst(rst), .digit(digit), .segments(segments), .check(check),
    .exp_value(exp_value), .exp_minus(exp_minus), .checks(checks), .errors(errors)
  );

  ////////////////////
  // PS/2 device model
  task automatic send_frame(input logic [7:0] data, input logic bad_parity);
    logic [10:0] bits;
    bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};   // stop, odd parity, data, start
    for (int i = 0; i < `CALC_PS2_BITS; i++) begin
      ps2_data <= bits[i];
      repeat (40) @(posedge clk);
      ps2_clk <= 1'b0;                                 // host samples on the fall
      repeat (40) @(posedge clk);
      ps2_clk <= 1'b1;
    end
    repeat (20 + $urandom % 41) @(posedge clk);        // idle gap
  endtask

  task automatic press_key(input logic [7:0] token);
    logic [7:0] code;
    code = token;
    if (token < 8'd10) begin
      code = ($urandom % 2) ? `CALC_PAD_CODE(token) : `CALC_ROW_CODE(token);
    end
    if (token != k_nil) begin
      case (token)
        k_bad: send_frame(`CALC_ROW_CODE(6), 1'b1);
        k_rel: begin
          send_frame(k_rel, 1'b0);
          send_frame(`CALC_ROW_CODE(2), 1'b0);
        end
        k_ext: begin
          send_frame(k_ext, 1'b0);
          send_frame(`CALC_PAD_CODE(1), 1'b0);
          send_frame(k_ext, 1'b0);
          send_frame(k_rel, 1'b0);
          send_frame(`CALC_PAD_CODE(1), 1'b0);
        end
        default: begin                                 // make, break, make
          send_frame(code, 1'b0);
          send_frame(k_rel, 1'b0);
          send_frame(code, 1'b0);
        end
      endcase
    end
  endtask

  ////////////////////
  // table loop
  initial begin
    void'($urandom(32'h28c0875f));
    rst = 1'b1;
    ps2_clk = 1'b1;
    ps2_data = 1'b1;
    check = 1'b0;
    exp_value = '0;
    exp_minus = 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    for (int r = 0; r < n_rows; r++) begin
      for (int k = 0; k < 6; k++) begin
        press_key(rows_tab[r][60-8*k -: 8]);
      end
      repeat (200) @(posedge clk);
      check     <= 1'b1;
      exp_value <= rows_tab[r][12:1];
      exp_minus <= rows_tab[r][0];
      @(posedge clk);
      check <= 1'b0;
    end
    repeat (2) @(posedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("timeout: key table not finished after %0d cycles", cycles);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("Test failed");
      $finish;
    end
  end

endmodule
